// File: ex_mem_cfg.svh
// ex_mem config: shared widths, flag bit positions and pc reset value
`ifndef EX_MEM_CFG_SVH
`define EX_MEM_CFG_SVH

// datapath and register file
`define EX_MEM_DATA_W 16
`define EX_MEM_REG_AW 4

// flags are ordered Z, V, N from msb down
`define EX_MEM_FLAG_W 3
`define EX_MEM_FLAG_Z 2
`define EX_MEM_FLAG_V 1
`define EX_MEM_FLAG_N 0

// value the registered branch target takes out of reset
`define EX_MEM_PC_RST 16'h0000

`endif

// File: ex_mem_pkg.sv
// ex_mem package: opcode and branch condition encodings, instruction word views
`include "ex_mem_cfg.svh"
`default_nettype none

package ex_mem_pkg;

  // values 13 and 14 are unused and decode as no-ops
  typedef enum logic [3:0] {
    OP_ADD = 4'd0,
    OP_SUB = 4'd1,
    OP_AND = 4'd2,
    OP_OR  = 4'd3,
    OP_XOR = 4'd4,
    OP_SLL = 4'd5,
    OP_SRL = 4'd6,
    OP_SRA = 4'd7,
    OP_LW  = 4'd8,
    OP_SW  = 4'd9,
    OP_LHB = 4'd10,
    OP_LLB = 4'd11,
    OP_B   = 4'd12,
    OP_HLT = 4'd15
  } opcode_e;

  typedef enum logic [2:0] {
    COND_NE     = 3'd0,
    COND_EQ     = 3'd1,
    COND_GT     = 3'd2,
    COND_LT     = 3'd3,
    COND_GE     = 3'd4,
    COND_LE     = 3'd5,
    COND_OV     = 3'd6,
    COND_UNCOND = 3'd7
  } cond_e;

  typedef struct packed {
    opcode_e                   opcode;
    logic [`EX_MEM_REG_AW-1:0] rd;
    logic [`EX_MEM_REG_AW-1:0] rs;
    logic [3:0]                imm4;
  } r_fmt_t;

  typedef struct packed {
    opcode_e    opcode;
    cond_e      cond;
    logic [8:0] offset;
  } b_fmt_t;

  // same 16-bit word, register form or branch form
  typedef union packed {
    r_fmt_t r_fmt;
    b_fmt_t b_fmt;
  } instr_u;

endpackage

`default_nettype wire

// File: ex_alu.sv
// ex_alu: saturating add/sub, logic, shifts, byte loads and address calc with flags
`include "ex_mem_cfg.svh"
`timescale 1ns/1ps
`default_nettype none

module ex_alu (
  input  ex_mem_pkg::instr_u         instr,
  input  logic [`EX_MEM_DATA_W-1:0]  op_a,
  input  logic [`EX_MEM_DATA_W-1:0]  op_b,
  output logic [`EX_MEM_DATA_W-1:0]  result,
  output logic [`EX_MEM_FLAG_W-1:0]  flags,
  output logic [`EX_MEM_FLAG_W-1:0]  flags_we
);

  ex_mem_pkg::opcode_e        op;
  logic [`EX_MEM_DATA_W-1:0] sum;
  logic [`EX_MEM_DATA_W-1:0] diff;
  logic [`EX_MEM_DATA_W-1:0] sat_val;
  logic [`EX_MEM_DATA_W-1:0] addr_off;
  logic [7:0]                imm8;
  logic                      add_ovf;
  logic                      sub_ovf;
  logic                      ovf;

  assign op   = instr.r_fmt.opcode;
  assign imm8 = {instr.r_fmt.rd, instr.r_fmt.imm4};

  assign sum  = op_a + op_b;
  assign diff = op_a - op_b;

  // signed overflow from operand and result signs
  assign add_ovf = (op_a[15] == op_b[15]) && (sum[15] != op_a[15]);
  assign sub_ovf = (op_a[15] != op_b[15]) && (diff[15] != op_a[15]);

  // overflow always goes toward the sign of op_a
  assign sat_val = op_a[15] ? 16'h8000 : 16'h7fff;

  // word address step, imm4 counts halfwords
  assign addr_off = {{11{instr.r_fmt.imm4[3]}}, instr.r_fmt.imm4, 1'b0};

  always_comb begin
    result   = '0;
    ovf      = 1'b0;
    flags_we = '0;
    case (op)
      ex_mem_pkg::OP_ADD: begin
        result   = add_ovf ? sat_val : sum;
        ovf      = add_ovf;
        flags_we = '1;
      end
      ex_mem_pkg::OP_SUB: begin
        result   = sub_ovf ? sat_val : diff;
        ovf      = sub_ovf;
        flags_we = '1;
      end
      ex_mem_pkg::OP_AND: begin
        result                  = op_a & op_b;
        flags_we[`EX_MEM_FLAG_Z] = 1'b1;
      end
      ex_mem_pkg::OP_OR: begin
        result                  = op_a | op_b;
        flags_we[`EX_MEM_FLAG_Z] = 1'b1;
      end
      ex_mem_pkg::OP_XOR: begin
        result                  = op_a ^ op_b;
        flags_we[`EX_MEM_FLAG_Z] = 1'b1;
      end
      ex_mem_pkg::OP_SLL: begin
        result                  = op_a << instr.r_fmt.imm4;
        flags_we[`EX_MEM_FLAG_Z] = 1'b1;
      end
      ex_mem_pkg::OP_SRL: begin
        result                  = op_a >> instr.r_fmt.imm4;
        flags_we[`EX_MEM_FLAG_Z] = 1'b1;
      end
      ex_mem_pkg::OP_SRA: begin
        result                  = $signed(op_a) >>> instr.r_fmt.imm4;
        flags_we[`EX_MEM_FLAG_Z] = 1'b1;
      end
      ex_mem_pkg::OP_LW,
      ex_mem_pkg::OP_SW: begin
        result = op_a + addr_off;
      end
      ex_mem_pkg::OP_LHB: begin
        result = {imm8, op_a[7:0]};
      end
      ex_mem_pkg::OP_LLB: begin
        result = {op_a[15:8], imm8};
      end
      default: begin
        result = '0;
      end
    endcase
  end

  // flags_we picks which of these reach the flag register
  always_comb begin
    flags                 = '0;
    flags[`EX_MEM_FLAG_Z] = (result == '0);
    flags[`EX_MEM_FLAG_V] = ovf;
    flags[`EX_MEM_FLAG_N] = result[`EX_MEM_DATA_W-1];
  end

endmodule

`default_nettype wire

// File: branch_resolve.sv
// branch_resolve: conditional branch test on the flag register and pc-relative target
`include "ex_mem_cfg.svh"
`timescale 1ns/1ps
`default_nettype none

module branch_resolve (
  input  ex_mem_pkg::instr_u        instr,
  input  logic [`EX_MEM_DATA_W-1:0] pc,
  input  logic [`EX_MEM_FLAG_W-1:0] flag_reg,
  output logic                      taken,
  output logic [`EX_MEM_DATA_W-1:0] target
);

  logic z;
  logic v;
  logic n;
  logic cond_met;

  assign z = flag_reg[`EX_MEM_FLAG_Z];
  assign v = flag_reg[`EX_MEM_FLAG_V];
  assign n = flag_reg[`EX_MEM_FLAG_N];

  always_comb begin
    case (instr.b_fmt.cond)
      ex_mem_pkg::COND_NE:     cond_met = !z;
      ex_mem_pkg::COND_EQ:     cond_met = z;
      ex_mem_pkg::COND_GT:     cond_met = !z && !n;
      ex_mem_pkg::COND_LT:     cond_met = n;
      ex_mem_pkg::COND_GE:     cond_met = !n;
      ex_mem_pkg::COND_LE:     cond_met = z || n;
      ex_mem_pkg::COND_OV:     cond_met = v;
      ex_mem_pkg::COND_UNCOND: cond_met = 1'b1;
      default:                 cond_met = 1'b0;
    endcase
  end

  assign taken = (instr.b_fmt.opcode == ex_mem_pkg::OP_B) && cond_met;

  // offset is relative to the next instruction
  assign target = pc + 16'd1 + {{7{instr.b_fmt.offset[8]}}, instr.b_fmt.offset};

endmodule

`default_nettype wire

// File: ex_mem_pipe.sv
// ex_mem_pipe: EX/MEM register with control decode, flag register, stall hold and reset
`include "ex_mem_cfg.svh"
`timescale 1ns/1ps
`default_nettype none

module ex_mem_pipe (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      stall,
  input  logic                      ex_valid,
  input  ex_mem_pkg::instr_u        ex_instr,
  input  logic [`EX_MEM_DATA_W-1:0] alu_result,
  input  logic [`EX_MEM_FLAG_W-1:0] alu_flags,
  input  logic [`EX_MEM_FLAG_W-1:0] flags_we,
  input  logic                      branch_taken,
  input  logic [`EX_MEM_DATA_W-1:0] branch_target,
  input  logic [`EX_MEM_DATA_W-1:0] ex_store_data,
  output logic [`EX_MEM_FLAG_W-1:0] flag_reg,
  output logic                      mem_valid,
  output logic [`EX_MEM_REG_AW-1:0] mem_rd,
  output logic                      mem_reg_write,
  output logic                      mem_mem_read,
  output logic                      mem_mem_write,
  output logic                      mem_mem_to_reg,
  output logic [`EX_MEM_DATA_W-1:0] mem_alu_result,
  output logic [`EX_MEM_DATA_W-1:0] mem_store_data,
  output logic                      mem_branch_taken,
  output logic [`EX_MEM_DATA_W-1:0] mem_branch_target,
  output logic                      mem_hlt,
  output logic [`EX_MEM_FLAG_W-1:0] mem_flags
);

  ex_mem_pkg::opcode_e op;
  logic                is_alu;
  logic                dec_reg_write;
  logic                dec_mem_read;
  logic                dec_mem_write;
  logic                dec_hlt;
  logic                dec_taken;

  assign op = ex_instr.r_fmt.opcode;

  // opcodes 0 to 7 are the register alu ops
  assign is_alu = (op[3] == 1'b0);

  assign dec_reg_write = ex_valid && (is_alu || op == ex_mem_pkg::OP_LHB ||
                         op == ex_mem_pkg::OP_LLB || op == ex_mem_pkg::OP_LW);
  assign dec_mem_read  = ex_valid && (op == ex_mem_pkg::OP_LW);
  assign dec_mem_write = ex_valid && (op == ex_mem_pkg::OP_SW);
  assign dec_hlt       = ex_valid && (op == ex_mem_pkg::OP_HLT);
  assign dec_taken     = ex_valid && branch_taken;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mem_valid         <= 1'b0;
      mem_rd            <= '0;
      mem_reg_write     <= 1'b0;
      mem_mem_read      <= 1'b0;
      mem_mem_write     <= 1'b0;
      mem_mem_to_reg    <= 1'b0;
      mem_alu_result    <= '0;
      mem_store_data    <= '0;
      mem_branch_taken  <= 1'b0;
      mem_branch_target <= `EX_MEM_PC_RST;
      mem_hlt           <= 1'b0;
    end else if (!stall) begin
      mem_valid         <= ex_valid;
      mem_rd            <= ex_instr.r_fmt.rd;
      mem_reg_write     <= dec_reg_write;
      mem_mem_read      <= dec_mem_read;
      mem_mem_write     <= dec_mem_write;
      mem_mem_to_reg    <= dec_mem_read;
      mem_alu_result    <= alu_result;
      mem_store_data    <= ex_store_data;
      mem_branch_taken  <= dec_taken;
      mem_branch_target <= branch_target;
      mem_hlt           <= dec_hlt;
    end
  end

  // per-flag update, logic ops touch Z only
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      flag_reg <= '0;
    end else if (!stall && ex_valid) begin
      flag_reg <= (flag_reg & ~flags_we) | (alu_flags & flags_we);
    end
  end

  assign mem_flags = flag_reg;

endmodule

`default_nettype wire

// File: ex_mem_stage.sv
// ex_mem_stage: execute stage alu and branch resolver feeding the EX/MEM register
`include "ex_mem_cfg.svh"
`timescale 1ns/1ps
`default_nettype none

module ex_mem_stage (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      stall,
  input  logic                      ex_valid,
  input  ex_mem_pkg::instr_u        ex_instr,
  input  logic [`EX_MEM_DATA_W-1:0] ex_pc,
  input  logic [`EX_MEM_DATA_W-1:0] ex_op_a,
  input  logic [`EX_MEM_DATA_W-1:0] ex_op_b,
  input  logic [`EX_MEM_DATA_W-1:0] ex_store_data,
  output logic                      mem_valid,
  output logic [`EX_MEM_REG_AW-1:0] mem_rd,
  output logic                      mem_reg_write,
  output logic                      mem_mem_read,
  output logic                      mem_mem_write,
  output logic                      mem_mem_to_reg,
  output logic [`EX_MEM_DATA_W-1:0] mem_alu_result,
  output logic [`EX_MEM_DATA_W-1:0] mem_store_data,
  output logic                      mem_branch_taken,
  output logic [`EX_MEM_DATA_W-1:0] mem_branch_target,
  output logic                      mem_hlt,
  output logic [`EX_MEM_FLAG_W-1:0] mem_flags
);

  logic [`EX_MEM_DATA_W-1:0] alu_result;
  logic [`EX_MEM_FLAG_W-1:0] alu_flags;
  logic [`EX_MEM_FLAG_W-1:0] alu_flags_we;
  logic [`EX_MEM_FLAG_W-1:0] flag_reg;
  logic                      branch_taken;
  logic [`EX_MEM_DATA_W-1:0] branch_target;

  ex_alu alu_i (
    .instr    (ex_instr),
    .op_a     (ex_op_a),
    .op_b     (ex_op_b),
    .result   (alu_result),
    .flags    (alu_flags),
    .flags_we (alu_flags_we)
  );

  // flags come back registered from the pipe
  branch_resolve br_i (
    .instr    (ex_instr),
    .pc       (ex_pc),
    .flag_reg (flag_reg),
    .taken    (branch_taken),
    .target   (branch_target)
  );

  ex_mem_pipe pipe_i (
    .clk               (clk),
    .rst_n             (rst_n),
    .stall             (stall),
    .ex_valid          (ex_valid),
    .ex_instr          (ex_instr),
    .alu_result        (alu_result),
    .alu_flags         (alu_flags),
    .flags_we          (alu_flags_we),
    .branch_taken      (branch_taken),
    .branch_target     (branch_target),
    .ex_store_data     (ex_store_data),
    .flag_reg          (flag_reg),
    .mem_valid         (mem_valid),
    .mem_rd            (mem_rd),
    .mem_reg_write     (mem_reg_write),
    .mem_mem_read      (mem_mem_read),
    .mem_mem_write     (mem_mem_write),
    .mem_mem_to_reg    (mem_mem_to_reg),
    .mem_alu_result    (mem_alu_result),
    .mem_store_data    (mem_store_data),
    .mem_branch_taken  (mem_branch_taken),
    .mem_branch_target (mem_branch_target),
    .mem_hlt           (mem_hlt),
    .mem_flags         (mem_flags)
  );

endmodule

`default_nettype wire

// File: ex_mem_props.sv
// ex_mem_props: concurrent checks on the EX/MEM register outputs
`include "ex_mem_cfg.svh"
`timescale 1ns/1ps
`default_nettype none

module ex_mem_props (
  input logic                      clk,
  input logic                      rst_n,
  input logic                      stall,
  input logic [`EX_MEM_FLAG_W-1:0] flag_reg,
  input logic                      mem_valid,
  input logic [`EX_MEM_REG_AW-1:0] mem_rd,
  input logic                      mem_reg_write,
  input logic                      mem_mem_read,
  input logic                      mem_mem_write,
  input logic                      mem_mem_to_reg,
  input logic [`EX_MEM_DATA_W-1:0] mem_alu_result,
  input logic [`EX_MEM_DATA_W-1:0] mem_store_data,
  input logic                      mem_branch_taken,
  input logic [`EX_MEM_DATA_W-1:0] mem_branch_target,
  input logic                      mem_hlt
);

  // every registered output and the flag register hold across a stall edge
  assert property (@(posedge clk) disable iff (!rst_n)
    stall |=> $stable({flag_reg, mem_valid, mem_rd, mem_reg_write, mem_mem_read,
                       mem_mem_write, mem_mem_to_reg, mem_alu_result, mem_store_data,
                       mem_branch_taken, mem_branch_target, mem_hlt}))
    else $error("outputs changed while stall was high");

  assert property (@(posedge clk) disable iff (!rst_n)
    !mem_valid |-> !(mem_reg_write || mem_mem_read || mem_mem_write ||
                     mem_mem_to_reg || mem_branch_taken || mem_hlt))
    else $error("control bit set on a bubble");

  assert property (@(posedge clk) disable iff (!rst_n)
    !(mem_mem_read && mem_mem_write))
    else $error("memory read and write both high");

endmodule

bind ex_mem_pipe ex_mem_props props_i (.*);

`default_nettype wire

// File: tb_ex_mem.sv
// tb_ex_mem: file-driven testbench for the execute to memory stage
`include "ex_mem_cfg.svh"
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
  output logic clk
);
  // 20 ns period
  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end
endmodule

module tb_ex_mem;

  logic                      clk;
  logic                      rst_n;
  logic                      stall;
  logic                      ex_valid;
  logic [15:0]               ex_instr;
  logic [`EX_MEM_DATA_W-1:0] ex_pc;
  logic [`EX_MEM_DATA_W-1:0] ex_op_a;
  logic [`EX_MEM_DATA_W-1:0] ex_op_b;
  logic [`EX_MEM_DATA_W-1:0] ex_store_data;
  logic                      mem_valid;
  logic [`EX_MEM_REG_AW-1:0] mem_rd;
  logic                      mem_reg_write;
  logic                      mem_mem_read;
  logic                      mem_mem_write;
  logic                      mem_mem_to_reg;
  logic [`EX_MEM_DATA_W-1:0] mem_alu_result;
  logic [`EX_MEM_DATA_W-1:0] mem_store_data;
  logic                      mem_branch_taken;
  logic [`EX_MEM_DATA_W-1:0] mem_branch_target;
  logic                      mem_hlt;
  logic [`EX_MEM_FLAG_W-1:0] mem_flags;

  // columns of one row, then the expected half kept for the next check
  logic [15:0] col [15];
  logic [15:0] exp_col [15];
  string       row_name;
  string       exp_name;
  string       line;
  int          fd;
  int          n_read;
  int          n_lines;
  int          wait_cyc;
  bit          have_exp;

  tb_clk_gen clk_gen_i (.clk(clk));

  ex_mem_stage dut_i (
    .clk               (clk),
    .rst_n             (rst_n),
    .stall             (stall),
    .ex_valid          (ex_valid),
    .ex_instr          (ex_instr),
    .ex_pc             (ex_pc),
    .ex_op_a           (ex_op_a),
    .ex_op_b           (ex_op_b),
    .ex_store_data     (ex_store_data),
    .mem_valid         (mem_valid),
    .mem_rd            (mem_rd),
    .mem_reg_write     (mem_reg_write),
    .mem_mem_read      (mem_mem_read),
    .mem_mem_write     (mem_mem_write),
    .mem_mem_to_reg    (mem_mem_to_reg),
    .mem_alu_result    (mem_alu_result),
    .mem_store_data    (mem_store_data),
    .mem_branch_taken  (mem_branch_taken),
    .mem_branch_target (mem_branch_target),
    .mem_hlt           (mem_hlt),
    .mem_flags         (mem_flags)
  );

  task automatic fail_run(input string why);
    $display("Some tests failed");
    $fatal(1, "%s", why);
  endtask

  task automatic check_field(input string test, input string field,
                             input logic [15:0] expv, input logic [15:0] actv);
    assert (actv === expv) else begin
      $display("[ERROR] %s %s: expected %h, actual %h", test, field, expv, actv);
      fail_run("output mismatch");
    end
  endtask

  // ctrl packs reg_write, mem_read, mem_write, mem_to_reg, hlt from msb down
  task automatic check_outputs(input string test);
    check_field(test, "mem_valid", exp_col[7], 16'(mem_valid));
    check_field(test, "ctrl", exp_col[8], 16'({mem_reg_write, mem_mem_read,
                mem_mem_write, mem_mem_to_reg, mem_hlt}));
    check_field(test, "mem_rd", exp_col[9], 16'(mem_rd));
    check_field(test, "mem_alu_result", exp_col[10], mem_alu_result);
    check_field(test, "mem_store_data", exp_col[11], mem_store_data);
    check_field(test, "mem_branch_taken", exp_col[12], 16'(mem_branch_taken));
    check_field(test, "mem_branch_target", exp_col[13], mem_branch_target);
    check_field(test, "mem_flags", exp_col[14], 16'(mem_flags));
  endtask

  initial begin
    rst_n = 1'b0;
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
  end

  initial begin
    stall         = 1'b0;
    ex_valid      = 1'b0;
    ex_instr      = '0;
    ex_pc         = '0;
    ex_op_a       = '0;
    ex_op_b       = '0;
    ex_store_data = '0;
    have_exp      = 1'b0;
    n_lines       = 0;

    // leaves on the falling edge right after release, before the pipe clocks again
    wait_cyc = 0;
    while (rst_n !== 1'b1) begin
      @(negedge clk);
      wait_cyc++;
      if (wait_cyc > 20) fail_run("reset was never released");
    end

    // reset state, nothing issued yet
    for (int i = 7; i < 15; i++) exp_col[i] = '0;
    check_outputs("after_reset");

    fd = $fopen("ex_mem_stimulus.txt", "r");
    if (fd == 0) fail_run("cannot open stimulus file ex_mem_stimulus.txt");

    while ($fgets(line, fd) != 0) begin
      n_lines++;
      if (n_lines > 500) fail_run("stimulus file did not end within 500 lines");
      if (line.len() > 1 && line.substr(0, 0) != "#") begin
        n_read = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %s",
                         col[0], col[1], col[2], col[3], col[4], col[5], col[6],
                         col[7], col[8], col[9], col[10], col[11], col[12],
                         col[13], col[14], row_name);
        if (n_read != 16) fail_run("malformed row in stimulus file");
        @(posedge clk);
        stall         <= col[0][0];
        ex_valid      <= col[1][0];
        ex_instr      <= col[2];
        ex_pc         <= col[3];
        ex_op_a       <= col[4];
        ex_op_b       <= col[5];
        ex_store_data <= col[6];
        @(negedge clk);
        if (have_exp) check_outputs(exp_name);
        exp_col  = col;
        exp_name = row_name;
        have_exp = 1'b1;
      end
    end
    $fclose(fd);

    // last row lands on this edge, then the pipe holds
    @(posedge clk);
    stall    <= 1'b1;
    ex_valid <= 1'b0;
    @(negedge clk);
    if (have_exp) check_outputs(exp_name);

    $display("All tests passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: ex_mem.f
+incdir+.
ex_mem_pkg.sv
ex_alu.sv
branch_resolve.sv
ex_mem_pipe.sv
ex_mem_stage.sv
ex_mem_props.sv
tb_ex_mem.sv

// File: run_sim.sh
#!/bin/sh
# build and run the ex_mem testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f ex_mem.f --top-module tb_ex_mem
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/Vtb_ex_mem)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -q "All tests passed"; then
  exit 0
fi
exit 1

// File: ex_mem_stimulus.txt
# stall valid instr pc op_a op_b store_data | exp: valid ctrl rd alu_result store_data
# taken target flags name   (ctrl = reg_write,mem_read,mem_write,mem_to_reg,hlt; flags = Z,V,N)
0 1 0201 0010 0005 0003 0000 1 10 2 0008 0000 0 0012 0 add_basic
0 1 0200 0030 7fff 0001 0000 1 10 2 7fff 0000 0 0031 2 add_ovf_pos
0 1 0200 0040 8000 ffff 0000 1 10 2 8000 0000 0 0041 3 add_ovf_neg
0 1 1200 0050 1234 1234 0000 1 10 2 0000 0000 0 0051 4 sub_zero
0 1 1200 0060 0003 0005 0000 1 10 2 fffe 0000 0 0061 1 sub_neg
0 1 1200 0070 8000 0001 0000 1 10 2 8000 0000 0 0071 3 sub_ovf
0 1 2200 0080 00f0 0f00 0000 1 10 2 0000 0000 0 0081 7 and_z
0 1 3200 0090 00f0 0f00 0000 1 10 2 0ff0 0000 0 0091 3 or_nz
0 1 4200 00a0 ffff ffff 0000 1 10 2 0000 0000 0 00a1 7 xor_z
0 1 5204 00b0 1234 0000 0000 1 10 2 2340 0000 0 00b5 3 sll
0 1 6204 00c0 8234 0000 0000 1 10 2 0823 0000 0 00c5 3 srl
0 1 7204 00d0 8234 0000 0000 1 10 2 f823 0000 0 00d5 3 sra
0 1 a20b 00e0 1234 0000 0000 1 10 2 2b34 0000 0 00ec 3 lhb
0 1 b20b 00f0 1234 0000 0000 1 10 2 122b 0000 0 00fc 3 llb
0 1 820e 0100 0100 0000 0000 1 1a 2 00fc 0000 0 010f 3 lw_neg
0 1 9205 0120 0200 0000 beef 1 04 2 020a beef 0 0126 3 sw
0 1 0200 0130 0001 ffff 0000 1 10 2 0000 0000 0 0131 4 add_set_z
0 1 c210 0140 0000 0000 0000 1 00 2 0000 0000 1 0151 4 beq_taken
0 1 c010 0150 0000 0000 0000 1 00 0 0000 0000 0 0161 4 bne_not
0 1 ca10 0160 0000 0000 0000 1 00 a 0000 0000 1 0171 4 ble_taken
0 1 c410 0170 0000 0000 0000 1 00 4 0000 0000 0 0181 4 bgt_not
0 1 c810 0180 0000 0000 0000 1 00 8 0000 0000 1 0191 4 bge_taken
0 1 c610 0190 0000 0000 0000 1 00 6 0000 0000 0 01a1 4 blt_not
0 1 cc10 01a0 0000 0000 0000 1 00 c 0000 0000 0 01b1 4 bov_not
0 1 cff0 01b0 0000 0000 0000 1 00 f 0000 0000 1 01a1 4 buncond_back
0 1 1200 01c0 0003 0005 0000 1 10 2 fffe 0000 0 01c1 1 sub_set_n
0 1 c610 01d0 0000 0000 0000 1 00 6 0000 0000 1 01e1 1 blt_taken
0 1 c810 01e0 0000 0000 0000 1 00 8 0000 0000 0 01f1 1 bge_not
0 1 c210 01f0 0000 0000 0000 1 00 2 0000 0000 0 0201 1 beq_not
0 1 c010 0200 0000 0000 0000 1 00 0 0000 0000 1 0211 1 bne_taken
0 1 0201 0210 0005 0003 0000 1 10 2 0008 0000 0 0212 0 add_clear
0 1 c410 0220 0000 0000 0000 1 00 4 0000 0000 1 0231 0 bgt_taken
0 1 ca10 0230 0000 0000 0000 1 00 a 0000 0000 0 0241 0 ble_not
0 1 0200 0240 7fff 0001 0000 1 10 2 7fff 0000 0 0241 2 add_set_v
1 1 0200 0250 0001 ffff 0000 1 10 2 7fff 0000 0 0241 2 stall_hold
0 1 cc10 0260 0000 0000 0000 1 00 c 0000 0000 1 0271 2 bov_taken
0 0 0200 0270 0005 0003 0000 0 00 2 0008 0000 0 0271 2 bubble_add
0 0 ce10 0280 0000 0000 0000 0 00 e 0000 0000 0 0291 2 bubble_branch
0 1 f000 0290 0000 0000 0000 1 01 0 0000 0000 0 0291 2 halt
